// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build bk_main_tb with Verilator and run it"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module bk_main_tb -o bk_sim
	./obj_dir/bk_sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "TEST FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== common/bk_defines.svh ====
`ifndef BK_DEFINES_SVH
`define BK_DEFINES_SVH

// ============================================================
// VGA timing, 640x480 frame at 25 MHz pixel clock
// ============================================================
`define BK_H_TOTAL      10'd800
`define BK_H_VISIBLE    10'd512     // BK screen is 512 pixels wide
`define BK_V_TOTAL      10'd525
`define BK_V_VISIBLE    10'd480
`define BK_HS_START     10'd656
`define BK_HS_END       10'd752
`define BK_VS_START     10'd490
`define BK_VS_END       10'd492

// ============================================================
// Memory map
// ============================================================
`define BK_VIDEO_BASE   5'b00001    // Video RAM high address bits
`define BK_ROLL_OFFSET  8'o330      // Roll register value for an unscrolled screen
`define BK_BPT_ADDR     18'h08000   // Debug write here sets the breakpoint

// Button debounce counter width
`define BK_DEBOUNCE_BITS 8

`endif

// ==== common/bk_pkg.sv ====
package bk_pkg;

    // ============================================================
    // Data and address types
    // ============================================================

    // One RAM or CPU data word
    typedef logic [15:0] word_t;

    // SRAM word address, 256K words
    typedef logic [17:0] ram_addr_t;

    // CPU byte address as seen on the bus
    typedef logic [16:0] cpu_addr_t;

    // ============================================================
    // RAM ownership
    // ============================================================

    // Who drives the SRAM port in the current cycle
    typedef enum logic [1:0] {
        OWNER_IDLE  = 2'd0,
        OWNER_CPU   = 2'd1,
        OWNER_VIDEO = 2'd2,
        OWNER_DEBUG = 2'd3
    } ram_owner_e;

endpackage

// ==== sim/bk_main_assertions.sv ====
`timescale 1ns/1ps

`include "bk_defines.svh"

module bk_main_assertions (
    input logic               clk25,
    input logic               reset_in,
    input logic [9:0]         screen_x,
    input logic [9:0]         screen_y,
    input logic [7:0]         roll_i,
    input logic               cpu_pause_i,
    input logic               cpu_ce_o,
    input logic               cpu_reply_o,
    input logic               cpu_rdy_o,
    input logic               cpu_oe_n,
    input logic               cpu_we_n,
    input logic               ram_we_n_o,
    input logic               ram_oe_n_o,
    input bk_pkg::ram_addr_t  ram_addr_o,
    input bk_pkg::ram_owner_e owner_o
);

    import bk_pkg::*;

    logic       fetch_slot;
    logic [7:0] exp_row;        // Screen row after roll

    assign fetch_slot = (screen_x[3:0] == 4'h0);
    assign exp_row    = screen_y[8:1] - `BK_ROLL_OFFSET + roll_i;

    // ============================================================
    // SRAM port sharing
    // ============================================================
    a_one_strobe: assert property (@(posedge clk25) disable iff (reset_in)
        ram_we_n_o || ram_oe_n_o)
        else $error("RAM write and read strobes low together");

    // No CPU strobe may be pending while video reads
    a_video_owns_slot: assert property (@(posedge clk25) disable iff (reset_in)
        fetch_slot |-> (owner_o == OWNER_VIDEO) && cpu_oe_n && cpu_we_n
                       && ram_we_n_o && !ram_oe_n_o)
        else $error("CPU strobe or wrong owner in the video fetch slot");

    a_video_addr: assert property (@(posedge clk25) disable iff (reset_in)
        fetch_slot |-> ram_addr_o == {`BK_VIDEO_BASE, exp_row, screen_x[8:4]})
        else $error("Wrong video fetch address");

    // ============================================================
    // CPU bus timing
    // ============================================================
    a_ce_slots: assert property (@(posedge clk25) disable iff (reset_in)
        (screen_x[3:0] == 4'hf || fetch_slot || cpu_pause_i) |-> !cpu_ce_o)
        else $error("CPU clock enable high in a blocked slot");

    a_reply_pulse: assert property (@(posedge clk25) disable iff (reset_in)
        cpu_reply_o |=> !cpu_reply_o)
        else $error("CPU reply longer than one clock");

    // Reset state of the strobes and status
    a_reset_state: assert property (@(posedge clk25)
        reset_in |-> ram_we_n_o && cpu_oe_n && cpu_we_n && !cpu_reply_o && cpu_rdy_o)
        else $error("Outputs not idle during reset");

endmodule

// ==== sim/bk_main_tb.sv ====
`timescale 1ns/1ps

`include "bk_defines.svh"

module bk_main_tb;

    import bk_pkg::*;

    logic clk25, reset_in;
    logic cpu_pause_i, color_i, full_screen_i, enable_bpt_i, button_i;
    logic [7:0] roll_i;
    logic cpu_rd_i, cpu_wt_i, cpu_byte_i, cpu_ifetch_i;
    cpu_addr_t cpu_adr_i;
    word_t cpu_wdata_i, cpu_rdata_o, dbg_wdata_i, dbg_rdata_o, ram_wdata_o, ram_rdata_i;
    logic cpu_reply_o, cpu_ce_o, cpu_rdy_o, dbg_we_i, dbg_oe_i;
    ram_addr_t dbg_addr_i, ram_addr_o;
    logic ram_we_n_o, ram_oe_n_o, ram_lb_o, ram_ub_o, button_db_o;
    ram_owner_e owner_o;
    logic vga_red_o, vga_green_o, vga_blue_o, vga_hs_o, vga_vs_o;

    word_t mem [0:262143];      // SRAM model, one word per address
    int    value_errors;
    int    timeout_errors;

    tb_clock u_clock (.clk25_o(clk25), .reset_o(reset_in));

    bk_main DUT (.*);

    bind bk_main bk_main_assertions u_assertions (
        .clk25(clk25), .reset_in(reset_in), .screen_x(screen_x), .screen_y(screen_y),
        .roll_i(roll_i), .cpu_pause_i(cpu_pause_i), .cpu_ce_o(cpu_ce_o),
        .cpu_reply_o(cpu_reply_o), .cpu_rdy_o(cpu_rdy_o),
        .cpu_oe_n(u_ram_arbiter.cpu_oe_n), .cpu_we_n(u_ram_arbiter.cpu_we_n),
        .ram_we_n_o(ram_we_n_o), .ram_oe_n_o(ram_oe_n_o), .ram_addr_o(ram_addr_o),
        .owner_o(owner_o)
    );

    // ============================================================
    // SRAM model, lane selects active low
    // ============================================================
    assign ram_rdata_i = mem[ram_addr_o];

    always @(posedge clk25) begin
        if (!ram_we_n_o) begin
            if (!ram_lb_o) mem[ram_addr_o][7:0] <= ram_wdata_o[7:0];
            if (!ram_ub_o) mem[ram_addr_o][15:8] <= ram_wdata_o[15:8];
        end
    end

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            value_errors++;
            $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One CPU cycle, levels held until the reply pulse
    task automatic cpu_access(input logic wr, input logic bt, input logic fetch,
                              input cpu_addr_t adr, input word_t wd, output word_t rd);
        bit got;
        got = 0;
        rd = '0;
        cpu_adr_i = adr;
        cpu_wdata_i = wd;
        cpu_byte_i = bt;
        cpu_ifetch_i = fetch;
        cpu_rd_i = !wr;
        cpu_wt_i = wr;
        for (int n = 0; n < 32 && !got; n++) begin
            @(negedge clk25);
            if (cpu_reply_o) begin
                got = 1;
                rd = cpu_rdata_o;
            end
        end
        cpu_rd_i = 0;
        cpu_wt_i = 0;
        cpu_ifetch_i = 0;
        if (!got) begin
            timeout_errors++;
            $display("No CPU reply within 32 clocks for address %h", adr);
        end
    endtask

    task automatic wait_line(input int line);
        int n;
        for (n = 0; n < 500000; n++) begin
            if (DUT.screen_y == line && DUT.screen_x == 0) break;
            @(negedge clk25);
        end
        if (n == 500000) begin
            timeout_errors++;
            $display("Screen line %0d never started", line);
        end
    endtask

    task automatic wait_rdy(input logic level);
        int n;
        for (n = 0; n < 64 && cpu_rdy_o !== level; n++) @(negedge clk25);
        if (n == 64) begin
            timeout_errors++;
            $display("CPU ready did not go to %0b within 64 clocks", level);
        end
    endtask

    initial begin
        word_t w, r, vword;
        cpu_addr_t a;
        logic [7:0] b;
        int x;
        int n;
        void'($urandom(41562));
        value_errors = 0;
        timeout_errors = 0;
        {cpu_pause_i, color_i, enable_bpt_i, button_i} = '0;
        {cpu_rd_i, cpu_wt_i, cpu_byte_i, cpu_ifetch_i, dbg_we_i, dbg_oe_i} = '0;
        full_screen_i = 1;
        roll_i = `BK_ROLL_OFFSET;
        cpu_adr_i = '0;
        cpu_wdata_i = '0;
        dbg_addr_i = '0;
        dbg_wdata_i = '0;
        for (int i = 0; i < 262144; i++) mem[i] = 16'(i) ^ 16'(i >> 2) ^ 16'h5a5a;

        // Idle outputs while reset is held
        for (int n = 0; n < 8 && reset_in; n++) begin
            @(negedge clk25);
            if (reset_in) begin
                check_word("reset strobe/reply/rdy", {ram_we_n_o, cpu_reply_o, cpu_rdy_o}, 3'b101);
                check_word("reset rgb", {vga_red_o, vga_green_o, vga_blue_o}, 0);
            end
        end
        @(negedge clk25);

        // ============================================================
        // CPU word and byte accesses, random roll underneath
        // ============================================================
        roll_i = 8'($urandom);
        for (int i = 0; i < 8; i++) begin
            a = 17'($urandom) & 17'h1fffe;
            w = 16'($urandom);
            b = 8'($urandom);
            cpu_access(1, 0, 0, a, w, r);
            cpu_access(0, 0, 0, a, 0, r);
            check_word("cpu read data", r, w);
            cpu_access(1, 1, 0, a | 17'd1, {b, b}, r);
            check_word("upper byte write", mem[{2'b00, a[16:1]}], {b, w[7:0]});
            cpu_access(1, 1, 0, a, {~b, ~b}, r);
            check_word("lower byte write", mem[{2'b00, a[16:1]}], {b, ~b});
        end

        // ============================================================
        // Mono pixels of line 100, word column 3
        // ============================================================
        roll_i = `BK_ROLL_OFFSET;
        vword = 16'ha5c3;
        mem[{`BK_VIDEO_BASE, 8'd50, 5'd3}] = vword;
        wait_line(100);
        check_word("vsync in line 100", vga_vs_o, 1);
        for (int i = 0; i < 800; i++) begin
            x = DUT.screen_x;
            check_word("hsync", vga_hs_o, !(x >= `BK_HS_START && x < `BK_HS_END));
            if (x >= 50 && x < 66)
                check_word($sformatf("pixel x=%0d", x), {vga_red_o, vga_green_o, vga_blue_o},
                           {3{vword[x - 50]}});
            else if (x >= 514)
                check_word("border rgb", {vga_red_o, vga_green_o, vga_blue_o}, 0);
            @(negedge clk25);
        end
        full_screen_i = 0;
        wait_line(200);
        for (int i = 0; i < 800; i++) begin
            check_word("lower region rgb", {vga_red_o, vga_green_o, vga_blue_o}, 0);
            @(negedge clk25);
        end
        full_screen_i = 1;
        wait_line(`BK_VS_START);
        check_word("vsync in sync line", vga_vs_o, 0);

        // ============================================================
        // Breakpoint set through the debug port
        // ============================================================
        w = 16'($urandom) & 16'hfffe;
        cpu_pause_i = 1;
        dbg_addr_i = `BK_BPT_ADDR;
        dbg_wdata_i = w;
        if (DUT.screen_x[3:0] == 4'h0) @(negedge clk25);   // Video owns this cycle
        dbg_we_i = 1;
        @(negedge clk25);
        dbg_we_i = 0;
        dbg_oe_i = 1;
        if (DUT.screen_x[3:0] == 4'h0) @(negedge clk25);
        check_word("debug read data", dbg_rdata_o, w);
        dbg_oe_i = 0;
        cpu_pause_i = 0;
        enable_bpt_i = 1;
        cpu_access(0, 0, 1, {1'b0, w}, 0, r);
        wait_rdy(0);
        check_word("rdy after breakpoint", cpu_rdy_o, 0);
        button_i = 1;
        wait_rdy(1);
        button_i = 0;
        check_word("rdy after button", cpu_rdy_o, 1);
        check_word("debounce after button", button_db_o, 1);

        // Debounce runs 255 enabled clocks
        for (n = 0; n < 400 && button_db_o; n++) @(negedge clk25);
        if (button_db_o) begin
            timeout_errors++;
            $display("Button debounce still active after 400 clocks");
        end
        check_word("debounce length", n >= 255, 1);

        enable_bpt_i = 0;
        cpu_access(0, 0, 1, {1'b0, w}, 0, r);
        for (int i = 0; i < 40; i++) begin
            check_word("rdy with breakpoint off", cpu_rdy_o, 1);
            @(negedge clk25);
        end

        $display("errors: value %0d, timeout %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk25_o,
    output logic reset_o
);

    // 40 ns period, 25 MHz pixel clock
    initial begin
        clk25_o = 1'b0;
        forever #20 clk25_o = ~clk25_o;
    end

    // Reset held over the first 3 rising edges
    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk25_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== sources.f ====
+incdir+common
common/bk_pkg.sv
video/sync_gen.sv
video/pixel_shifter.sv
verilog/ram_arbiter.sv
verilog/debug_unit.sv
verilog/bk_main.sv
sim/tb_clock.sv
sim/bk_main_assertions.sv
sim/bk_main_tb.sv

// ==== verilog/bk_main.sv ====
`timescale 1ns/1ps

module bk_main (
    input  logic               clk25,
    input  logic               reset_in,
    input  logic               cpu_pause_i,
    input  logic [7:0]         roll_i,
    input  logic               color_i,
    input  logic               full_screen_i,
    input  logic               enable_bpt_i,
    input  logic               button_i,
    input  logic               cpu_rd_i,
    input  logic               cpu_wt_i,
    input  logic               cpu_byte_i,
    input  logic               cpu_ifetch_i,
    input  bk_pkg::cpu_addr_t  cpu_adr_i,
    input  bk_pkg::word_t      cpu_wdata_i,
    output bk_pkg::word_t      cpu_rdata_o,
    output logic               cpu_reply_o,
    output logic               cpu_ce_o,
    output logic               cpu_rdy_o,
    input  logic               dbg_we_i,
    input  logic               dbg_oe_i,
    input  bk_pkg::ram_addr_t  dbg_addr_i,
    input  bk_pkg::word_t      dbg_wdata_i,
    output bk_pkg::word_t      dbg_rdata_o,
    output bk_pkg::ram_addr_t  ram_addr_o,
    output bk_pkg::word_t      ram_wdata_o,
    output logic               ram_we_n_o,
    output logic               ram_oe_n_o,
    output logic               ram_lb_o,
    output logic               ram_ub_o,
    input  bk_pkg::word_t      ram_rdata_i,
    output bk_pkg::ram_owner_e owner_o,
    output logic               button_db_o,
    output logic               vga_red_o,
    output logic               vga_green_o,
    output logic               vga_blue_o,
    output logic               vga_hs_o,
    output logic               vga_vs_o
);

    logic [9:0] screen_x;
    logic [9:0] screen_y;
    logic       valid;
    logic       valid_full;
    logic       video_load;
    logic       pix_r;
    logic       pix_g;
    logic       pix_b;
    logic       dbg_we;
    logic       dbg_oe;
    logic       bpt_hit;

    // Debug port works only with the CPU paused
    assign dbg_we      = dbg_we_i & cpu_pause_i;
    assign dbg_oe      = dbg_oe_i & cpu_pause_i;
    assign dbg_rdata_o = ram_rdata_i;

    sync_gen u_sync_gen (
        .clk25      (clk25),
        .reset_in   (reset_in),
        .screen_x_o (screen_x),
        .screen_y_o (screen_y),
        .valid_o    (valid),
        .hsync_o    (vga_hs_o),
        .vsync_o    (vga_vs_o)
    );

    pixel_shifter u_pixel_shifter (
        .clk25    (clk25),
        .reset_in (reset_in),
        .load_i   (video_load),
        .data_i   (ram_rdata_i),
        .color_i  (color_i),
        .valid_i  (valid),
        .red_o    (pix_r),
        .green_o  (pix_g),
        .blue_o   (pix_b)
    );

    ram_arbiter u_ram_arbiter (
        .clk25        (clk25),
        .reset_in     (reset_in),
        .screen_x_i   (screen_x),
        .screen_y_i   (screen_y),
        .roll_i       (roll_i),
        .cpu_pause_i  (cpu_pause_i),
        .cpu_rd_i     (cpu_rd_i),
        .cpu_wt_i     (cpu_wt_i),
        .cpu_byte_i   (cpu_byte_i),
        .cpu_adr_i    (cpu_adr_i),
        .cpu_wdata_i  (cpu_wdata_i),
        .cpu_rdata_o  (cpu_rdata_o),
        .cpu_reply_o  (cpu_reply_o),
        .cpu_ce_o     (cpu_ce_o),
        .dbg_we_i     (dbg_we),
        .dbg_oe_i     (dbg_oe),
        .dbg_addr_i   (dbg_addr_i),
        .dbg_wdata_i  (dbg_wdata_i),
        .ram_rdata_i  (ram_rdata_i),
        .ram_addr_o   (ram_addr_o),
        .ram_wdata_o  (ram_wdata_o),
        .ram_we_n_o   (ram_we_n_o),
        .ram_oe_n_o   (ram_oe_n_o),
        .ram_lb_o     (ram_lb_o),
        .ram_ub_o     (ram_ub_o),
        .video_load_o (video_load),
        .owner_o      (owner_o)
    );

    debug_unit u_debug_unit (
        .clk25        (clk25),
        .reset_in     (reset_in),
        .ce_i         (cpu_ce_o),
        .dbg_we_i     (dbg_we),
        .dbg_addr_i   (dbg_addr_i),
        .dbg_wdata_i  (dbg_wdata_i),
        .enable_bpt_i (enable_bpt_i),
        .cpu_rd_i     (cpu_rd_i),
        .cpu_ifetch_i (cpu_ifetch_i),
        .cpu_adr_i    (cpu_adr_i),
        .button_i     (button_i),
        .bpt_hit_o    (bpt_hit),
        .button_db_o  (button_db_o)
    );

    assign cpu_rdy_o = ~bpt_hit;

    // ============================================================
    // Blanking and RGB output register
    // ============================================================

    // Lower region shows only in full screen mode
    assign valid_full = valid && (full_screen_i || (screen_y[8:7] == 2'b00));

    always_ff @(posedge clk25 or posedge reset_in) begin
        if (reset_in) begin
            vga_red_o   <= 1'b0;
            vga_green_o <= 1'b0;
            vga_blue_o  <= 1'b0;
        end else begin
            vga_red_o   <= valid_full & pix_r;
            vga_green_o <= valid_full & pix_g;
            vga_blue_o  <= valid_full & pix_b;
        end
    end

endmodule

// ==== verilog/debug_unit.sv ====
`timescale 1ns/1ps

`include "bk_defines.svh"

module debug_unit (
    input  logic              clk25,
    input  logic              reset_in,
    input  logic              ce_i,
    input  logic              dbg_we_i,
    input  bk_pkg::ram_addr_t dbg_addr_i,
    input  bk_pkg::word_t     dbg_wdata_i,
    input  logic              enable_bpt_i,
    input  logic              cpu_rd_i,
    input  logic              cpu_ifetch_i,
    input  bk_pkg::cpu_addr_t cpu_adr_i,
    input  logic              button_i,
    output logic              bpt_hit_o,
    output logic              button_db_o
);

    import bk_pkg::*;

    word_t                        bpt_addr;
    logic                         bpt_match;
    logic                         button_q;
    logic                         button_rise;
    logic [`BK_DEBOUNCE_BITS-1:0] db_cnt;

    // ============================================================
    // Breakpoint register and latch
    // ============================================================
    always_ff @(posedge clk25 or posedge reset_in) begin
        if (reset_in) begin
            bpt_addr <= '1;                     // Odd address, never fetched
        end else if (dbg_we_i && (dbg_addr_i == `BK_BPT_ADDR)) begin
            bpt_addr <= dbg_wdata_i;
        end
    end

    assign bpt_match = enable_bpt_i && cpu_rd_i && cpu_ifetch_i
                       && (cpu_adr_i == {1'b0, bpt_addr});

    // Button edge wins over a new match
    always_ff @(posedge clk25 or posedge reset_in) begin
        if (reset_in) begin
            bpt_hit_o <= 1'b0;
        end else if (ce_i) begin
            if (button_rise) begin
                bpt_hit_o <= 1'b0;
            end else if (bpt_match) begin
                bpt_hit_o <= 1'b1;
            end
        end
    end

    // ============================================================
    // Button sampling and debounce
    // ============================================================
    assign button_rise = button_i & ~button_q;

    always_ff @(posedge clk25 or posedge reset_in) begin
        if (reset_in) begin
            button_q <= 1'b0;
            db_cnt   <= '0;
        end else if (ce_i) begin
            button_q <= button_i;
            if (button_rise) begin
                db_cnt <= '1;
            end else if (|db_cnt) begin
                db_cnt <= db_cnt - 1'b1;
            end
        end
    end

    assign button_db_o = |db_cnt;   // High while the counter runs

endmodule

// ==== verilog/ram_arbiter.sv ====
`timescale 1ns/1ps

`include "bk_defines.svh"

module ram_arbiter (
    input  logic               clk25,
    input  logic               reset_in,
    input  logic [9:0]         screen_x_i,
    input  logic [9:0]         screen_y_i,
    input  logic [7:0]         roll_i,
    input  logic               cpu_pause_i,
    input  logic               cpu_rd_i,
    input  logic               cpu_wt_i,
    input  logic               cpu_byte_i,
    input  bk_pkg::cpu_addr_t  cpu_adr_i,
    input  bk_pkg::word_t      cpu_wdata_i,
    output bk_pkg::word_t      cpu_rdata_o,
    output logic               cpu_reply_o,
    output logic               cpu_ce_o,
    input  logic               dbg_we_i,
    input  logic               dbg_oe_i,
    input  bk_pkg::ram_addr_t  dbg_addr_i,
    input  bk_pkg::word_t      dbg_wdata_i,
    input  bk_pkg::word_t      ram_rdata_i,
    output bk_pkg::ram_addr_t  ram_addr_o,
    output bk_pkg::word_t      ram_wdata_o,
    output logic               ram_we_n_o,
    output logic               ram_oe_n_o,
    output logic               ram_lb_o,
    output logic               ram_ub_o,
    output logic               video_load_o,
    output bk_pkg::ram_owner_e owner_o
);

    import bk_pkg::*;

    logic        ce_cpu;
    logic        video_slot;
    logic        cpu_oe_n;
    logic        cpu_we_n;
    logic        dbg_active;
    logic [7:0]  vga_row;
    logic [12:0] vga_addr;

    // ============================================================
    // CPU clock enable, never next to the video slot
    // ============================================================
    assign video_slot = (screen_x_i[3:0] == 4'h0);
    assign ce_cpu     = ~cpu_pause_i && (screen_x_i[3:0] != 4'hf) && !video_slot;

    assign cpu_ce_o     = ce_cpu;
    assign video_load_o = video_slot;

    // ============================================================
    // CPU exchange cycle
    // ============================================================
    always_ff @(posedge clk25 or posedge reset_in) begin
        if (reset_in) begin
            cpu_oe_n    <= 1'b1;
            cpu_we_n    <= 1'b1;
            cpu_reply_o <= 1'b0;
        end else begin
            cpu_reply_o <= ~cpu_oe_n | ~cpu_we_n;   // Strobe ends this clock
            if (ce_cpu) begin
                // Start only when idle and no reply is out
                cpu_oe_n <= ~cpu_rd_i | cpu_reply_o | ~cpu_oe_n;
                cpu_we_n <= ~cpu_wt_i | cpu_reply_o | ~cpu_we_n;
            end else begin
                cpu_oe_n <= 1'b1;
                cpu_we_n <= 1'b1;
            end
        end
    end

    // Read data captured with the end of the strobe
    always_ff @(posedge clk25) begin
        if (~cpu_oe_n) begin
            cpu_rdata_o <= ram_rdata_i;
        end
    end

    // Screen row with roll applied, then word column
    assign vga_row  = screen_y_i[8:1] - `BK_ROLL_OFFSET + roll_i;
    assign vga_addr = {vga_row, screen_x_i[8:4]};

    // ============================================================
    // Port owner and SRAM multiplexer
    // ============================================================
    assign dbg_active = dbg_we_i | dbg_oe_i;

    always_comb begin
        if (video_slot) begin
            owner_o = OWNER_VIDEO;
        end else if (dbg_active) begin
            owner_o = OWNER_DEBUG;
        end else if (~cpu_oe_n | ~cpu_we_n) begin
            owner_o = OWNER_CPU;
        end else begin
            owner_o = OWNER_IDLE;
        end
    end

    // Lane selects are active low
    always_comb begin
        ram_addr_o  = {2'b00, cpu_adr_i[16:1]};
        ram_wdata_o = cpu_wdata_i;
        ram_we_n_o  = 1'b1;
        ram_oe_n_o  = 1'b1;
        ram_lb_o    = 1'b0;
        ram_ub_o    = 1'b0;
        case (owner_o)
            OWNER_VIDEO: begin
                ram_addr_o = {`BK_VIDEO_BASE, vga_addr};
                ram_oe_n_o = 1'b0;              // Video only reads
            end
            OWNER_DEBUG: begin
                ram_addr_o  = dbg_addr_i;
                ram_wdata_o = dbg_wdata_i;
                ram_we_n_o  = ~dbg_we_i;
                ram_oe_n_o  = dbg_we_i | ~dbg_oe_i;
            end
            OWNER_CPU: begin
                ram_we_n_o = cpu_we_n;
                ram_oe_n_o = cpu_oe_n | ~cpu_we_n;
                ram_lb_o   = cpu_byte_i & cpu_adr_i[0];
                ram_ub_o   = cpu_byte_i & ~cpu_adr_i[0];
            end
            default: ram_oe_n_o = 1'b1;
        endcase
    end

endmodule

// ==== video/pixel_shifter.sv ====
`timescale 1ns/1ps

module pixel_shifter (
    input  logic          clk25,
    input  logic          reset_in,
    input  logic          load_i,
    input  bk_pkg::word_t data_i,
    input  logic          color_i,
    input  logic          valid_i,
    output logic          red_o,
    output logic          green_o,
    output logic          blue_o
);

    import bk_pkg::*;

    word_t      shift_q;
    logic       phase_q;        // Second clock of a color pixel
    logic [1:0] pair;

    // ============================================================
    // Shift register, LSB goes out first
    // ============================================================
    always_ff @(posedge clk25 or posedge reset_in) begin
        if (reset_in) begin
            shift_q <= '0;
            phase_q <= 1'b0;
        end else if (load_i && valid_i) begin
            shift_q <= data_i;
            phase_q <= 1'b0;
        end else if (!valid_i) begin
            shift_q <= '0;          // Nothing left over into the border
            phase_q <= 1'b0;
        end else if (color_i) begin
            phase_q <= ~phase_q;
            if (phase_q) begin
                shift_q <= {2'b00, shift_q[15:2]};
            end
        end else begin
            shift_q <= {1'b0, shift_q[15:1]};
        end
    end

    assign pair = shift_q[1:0];

    // BK palette in color mode, plain white in mono
    always_comb begin
        if (color_i) begin
            red_o   = (pair == 2'b11);
            green_o = (pair == 2'b10);
            blue_o  = (pair == 2'b01);
        end else begin
            red_o   = shift_q[0];
            green_o = shift_q[0];
            blue_o  = shift_q[0];
        end
    end

endmodule

// ==== video/sync_gen.sv ====
`timescale 1ns/1ps

`include "bk_defines.svh"

module sync_gen (
    input  logic       clk25,
    input  logic       reset_in,
    output logic [9:0] screen_x_o,
    output logic [9:0] screen_y_o,
    output logic       valid_o,
    output logic       hsync_o,
    output logic       vsync_o
);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_last;
    logic       v_last;
    logic       h_visible;
    logic       v_visible;

    assign h_last = (h_cnt == (`BK_H_TOTAL - 10'd1));
    assign v_last = (v_cnt == (`BK_V_TOTAL - 10'd1));

    // ============================================================
    // Pixel and line counters
    // ============================================================
    always_ff @(posedge clk25 or posedge reset_in) begin
        if (reset_in) begin
            h_cnt <= 10'd0;
        end else if (h_last) begin
            h_cnt <= 10'd0;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    // Line counter steps at the end of each line
    always_ff @(posedge clk25 or posedge reset_in) begin
        if (reset_in) begin
            v_cnt <= 10'd0;
        end else if (h_last) begin
            if (v_last) begin
                v_cnt <= 10'd0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end
    end

    // ============================================================
    // Sync pulses and visible area
    // ============================================================

    // Both syncs are active low
    assign hsync_o = ~((h_cnt >= `BK_HS_START) && (h_cnt < `BK_HS_END));
    assign vsync_o = ~((v_cnt >= `BK_VS_START) && (v_cnt < `BK_VS_END));

    assign h_visible = (h_cnt < `BK_H_VISIBLE);
    assign v_visible = (v_cnt < `BK_V_VISIBLE);
    assign valid_o   = h_visible && v_visible;

    assign screen_x_o = h_cnt;
    assign screen_y_o = v_cnt;

endmodule
